/* hdl/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;

    localparam word_t EXC_VECTOR_DEFAULT = 32'hBFC00380; // General exception vector, BEV = 1.

    // Operations as they leave the decoder.
    typedef enum logic [5:0] {
        NOP,
        ALU,
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB,
        SYSCALL,
        BREAK,
        ERET,
        MTC0,
        MFC0
    } decoded_op_t;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,  // Load or fetch address error.
        ADES = 5'd5,  // Store address error.
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14
    } cp0_addr_t;

    typedef struct packed {
        decoded_op_t op;
        word_t       raw;  // Undecoded instruction word.
    } instr_t;

    // One instruction as it arrives from execute.
    typedef struct packed {
        instr_t instr;
        word_t  pcplus4;
        word_t  result;           // ALU result, the memory address for loads and stores.
        logic   exception_instr;  // Fetch address error.
        logic   exception_ri;
        logic   exception_of;
        logic   in_delay_slot;
    } exec_data_t;

    typedef struct packed {
        logic [15:0] reserved_hi;  // CU, RP, FR, RE, MX, PX, BEV, TS, SR, NMI, Impl.
        logic [7:0]  IM;
        logic [5:0]  reserved_lo;  // KSU, ERL and friends.
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    typedef struct packed {
        logic        BD;
        logic        TI;
        logic [13:0] reserved_hi;
        logic [7:0]  IP;           // Only bits 1:0 are software writable.
        logic        reserved_7;
        exc_code_t   exc_code;
        logic [1:0]  reserved_lo;
    } cp0_cause_t;

    // Everything the priority encoder needs for one instruction.
    typedef struct packed {
        logic       exception_instr;
        logic       exception_ri;
        logic       exception_of;
        logic       exception_load;
        logic       exception_save;
        logic       exception_sys;
        logic       exception_bp;
        logic       in_delay_slot;
        word_t      pc;
        word_t      vaddr;
        logic [7:0] interrupt_info;  // Pending and unmasked IP bits.
        logic       is_eret;
    } exception_pipeline_t;

    // The exception chosen for this cycle.
    typedef struct packed {
        exc_code_t code;
        word_t     pc;     // Restart pc, already moved back over a branch.
        word_t     vaddr;
        logic      in_delay_slot;
        logic      is_eret;
    } exception_t;

endpackage

/* hdl/exception.sv */
`timescale 1ns/1ns

module exception #(
    parameter mips_pkg::word_t exc_vector = mips_pkg::EXC_VECTOR_DEFAULT
) (
    input  mips_pkg::exception_pipeline_t pipe,
    input  mips_pkg::cp0_status_t         cp0_status,
    input  mips_pkg::word_t               cp0_epc,
    output logic                          valid,
    output mips_pkg::word_t               pc_target,
    output mips_pkg::exception_t          info
);
    import mips_pkg::*;

    // Bit positions in the cause vector, lowest index wins.
    localparam int SEL_INT   = 0;
    localparam int SEL_FETCH = 1;
    localparam int SEL_RI    = 2;
    localparam int SEL_OV    = 3;
    localparam int SEL_SYS   = 4;
    localparam int SEL_BP    = 5;
    localparam int SEL_LOAD  = 6;
    localparam int SEL_SAVE  = 7;
    localparam int SEL_ERET  = 8;

    logic       take_int;
    logic [8:0] causes;
    logic [8:0] sel;
    exc_code_t  code;

    assign take_int = (pipe.interrupt_info != 8'h00) && cp0_status.IE && !cp0_status.EXL;

    assign causes[SEL_INT]   = take_int;
    assign causes[SEL_FETCH] = pipe.exception_instr;
    assign causes[SEL_RI]    = pipe.exception_ri;
    assign causes[SEL_OV]    = pipe.exception_of;
    assign causes[SEL_SYS]   = pipe.exception_sys;
    assign causes[SEL_BP]    = pipe.exception_bp;
    assign causes[SEL_LOAD]  = pipe.exception_load;
    assign causes[SEL_SAVE]  = pipe.exception_save;
    assign causes[SEL_ERET]  = pipe.is_eret;

    assign sel = causes & (~causes + 9'd1); // Isolate the lowest set bit.

    always_comb begin
        code = INT;
        unique case (1'b1)
            sel[SEL_INT]:   code = INT;
            sel[SEL_FETCH]: code = ADEL;
            sel[SEL_RI]:    code = RI;
            sel[SEL_OV]:    code = OV;
            sel[SEL_SYS]:   code = SYS;
            sel[SEL_BP]:    code = BP;
            sel[SEL_LOAD]:  code = ADEL;
            sel[SEL_SAVE]:  code = ADES;
            sel[SEL_ERET]:  code = INT;  // ERET carries no cause code.
            default:        code = INT;
        endcase
    end

    assign valid     = (causes != 9'd0);
    assign pc_target = sel[SEL_ERET] ? cp0_epc : exc_vector;

    assign info.code          = code;
    assign info.pc            = pipe.in_delay_slot ? pipe.pc - 32'd4 : pipe.pc; // Back to the branch.
    assign info.vaddr         = pipe.vaddr;
    assign info.in_delay_slot = pipe.in_delay_slot;
    assign info.is_eret       = sel[SEL_ERET];

    // The reported code belongs to one of the detected causes.
    always_comb begin
        code_matches_cause: assert final (!valid || info.is_eret ||
            (code == INT && causes[SEL_INT]) ||
            (code == ADEL && (causes[SEL_FETCH] || causes[SEL_LOAD])) ||
            (code == RI && causes[SEL_RI]) || (code == OV && causes[SEL_OV]) ||
            (code == SYS && causes[SEL_SYS]) || (code == BP && causes[SEL_BP]) ||
            (code == ADES && causes[SEL_SAVE]))
        else $error("exception: code does not match a detected cause");
    end

endmodule

/* hdl/exception_checker.sv */
`timescale 1ns/1ns

module exception_checker #(
    parameter mips_pkg::word_t exc_vector = mips_pkg::EXC_VECTOR_DEFAULT
) (
    input  logic                  reset,
    input  logic                  flush,
    input  mips_pkg::exec_data_t  in,
    input  logic [5:0]            ext_int,
    input  mips_pkg::cp0_status_t cp0_status,
    input  mips_pkg::cp0_cause_t  cp0_cause,
    input  mips_pkg::word_t       cp0_epc,
    output logic                  exception_valid,
    output mips_pkg::word_t       pcexception,
    output mips_pkg::exception_t  exception_data,
    output mips_pkg::exec_data_t  out
);
    import mips_pkg::*;

    exec_data_t          data;
    logic [5:0]          ext;
    decoded_op_t         op;
    word_t               addr;
    logic                misaligned_word;
    logic                misaligned_half;
    exception_pipeline_t pipe;

    logic                raw_valid;
    word_t               raw_target;
    exception_t          raw_info;

    assign data = reset ? '0 : in;
    assign ext  = reset ? '0 : ext_int;

    assign op   = data.instr.op;
    assign addr = data.result;

    assign misaligned_word = (addr[1:0] != 2'b00);
    assign misaligned_half = addr[0];

    assign pipe.exception_instr = data.exception_instr;
    assign pipe.exception_ri    = data.exception_ri;
    assign pipe.exception_of    = data.exception_of;
    assign pipe.exception_load  = ((op == LW) && misaligned_word) ||
                                  ((op == LH || op == LHU) && misaligned_half);
    assign pipe.exception_save  = ((op == SW) && misaligned_word) ||
                                  ((op == SH) && misaligned_half);
    assign pipe.exception_sys   = (op == SYSCALL);
    assign pipe.exception_bp    = (op == BREAK);
    assign pipe.is_eret         = (op == ERET);
    assign pipe.in_delay_slot   = data.in_delay_slot;
    assign pipe.pc              = data.pcplus4 - 32'd4;
    assign pipe.vaddr           = data.exception_instr ? pipe.pc : data.result; // Bad fetch pc.

    // Hardware lines sit in IP7..IP2, the timer shares IP7.
    assign pipe.interrupt_info = ({ext, 2'b00} | cp0_cause.IP | {cp0_cause.TI, 7'b0})
                                 & cp0_status.IM;

    exception #(
        .exc_vector(exc_vector)
    ) u_exception (
        .pipe      (pipe),
        .cp0_status(cp0_status),
        .cp0_epc   (cp0_epc),
        .valid     (raw_valid),
        .pc_target (raw_target),
        .info      (raw_info)
    );

    assign exception_valid = flush ? 1'b0 : raw_valid;
    assign pcexception     = flush ? '0 : raw_target;
    assign exception_data  = flush ? '0 : raw_info;
    assign out             = (flush || raw_valid) ? '0 : data; // Killed instructions go no further.

    // An exception needs some detected cause in this instruction.
    always_comb begin
        exception_has_cause: assert final (!exception_valid ||
            pipe.exception_instr || pipe.exception_ri || pipe.exception_of ||
            pipe.exception_load || pipe.exception_save || pipe.exception_sys ||
            pipe.exception_bp || pipe.is_eret || (pipe.interrupt_info != 8'h00))
        else $error("exception_checker: exception raised without a cause");
    end

endmodule

/* hdl/cp0_regs.sv */
`timescale 1ns/1ns

module cp0_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exception_valid,
    input  mips_pkg::exception_t  exception_data,
    input  logic                  we,
    input  mips_pkg::cp0_addr_t   waddr,
    input  mips_pkg::word_t       wdata,
    input  mips_pkg::cp0_addr_t   raddr,
    output mips_pkg::cp0_status_t status,
    output mips_pkg::cp0_cause_t  cause,
    output mips_pkg::word_t       epc,
    output mips_pkg::word_t       rdata
);
    import mips_pkg::*;

    cp0_status_t status_q;
    cp0_cause_t  cause_q;
    word_t       epc_q;
    word_t       badvaddr_q;
    word_t       count_q;
    word_t       compare_q;
    logic        count_phase;  // Count steps at half the clock rate.

    logic        take_exc;
    logic        take_eret;
    logic        addr_error;
    cp0_status_t wr_status;
    cp0_cause_t  wr_cause;

    assign take_exc   = exception_valid && !exception_data.is_eret;
    assign take_eret  = exception_valid && exception_data.is_eret;
    assign addr_error = (exception_data.code == ADEL) || (exception_data.code == ADES);

    assign wr_status = cp0_status_t'(wdata);
    assign wr_cause  = cp0_cause_t'(wdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_q     <= '0;
            status_q.EXL <= 1'b1;  // Start in kernel mode with interrupts held off.
            cause_q      <= '0;
            epc_q        <= '0;
            badvaddr_q   <= '0;
            count_q      <= '0;
            compare_q    <= '0;
            count_phase  <= 1'b0;
        end else begin
            count_phase <= ~count_phase;
            if (count_phase) begin
                count_q <= count_q + 32'd1;
            end
            if (count_q == compare_q) begin
                cause_q.TI <= 1'b1;
            end

            if (take_exc) begin
                status_q.EXL     <= 1'b1;
                cause_q.exc_code <= exception_data.code;
                cause_q.BD       <= exception_data.in_delay_slot;
                if (!status_q.EXL) begin
                    epc_q <= exception_data.pc;  // Nested exceptions keep the first EPC.
                end
                if (addr_error) begin
                    badvaddr_q <= exception_data.vaddr;
                end
            end else if (take_eret) begin
                status_q.EXL <= 1'b0;
            end else if (we) begin
                case (waddr)
                    STATUS: begin
                        status_q.IM  <= wr_status.IM;
                        status_q.EXL <= wr_status.EXL;
                        status_q.IE  <= wr_status.IE;
                    end
                    CAUSE: begin
                        cause_q.IP[1:0] <= wr_cause.IP[1:0];  // Software interrupts.
                    end
                    EPC: begin
                        epc_q <= wdata;
                    end
                    COUNT: begin
                        count_q <= wdata;
                    end
                    COMPARE: begin
                        compare_q  <= wdata;
                        cause_q.TI <= 1'b0;  // Acknowledges the timer.
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (raddr)
            BADVADDR: rdata = badvaddr_q;
            COUNT:    rdata = count_q;
            COMPARE:  rdata = compare_q;
            STATUS:   rdata = status_q;
            CAUSE:    rdata = cause_q;
            EPC:      rdata = epc_q;
            default:  rdata = '0;
        endcase
    end

    assign status = status_q;
    assign cause  = cause_q;
    assign epc    = epc_q;

    // A taken exception leaves EXL set, and a first-level one records its pc.
    exl_after_exception: assert property (
        @(posedge clk) disable iff (reset)
        take_exc |=> status_q.EXL
    ) else $error("cp0_regs: EXL not set after an exception");

    epc_on_first_exception: assert property (
        @(posedge clk) disable iff (reset)
        (take_exc && !status_q.EXL) |=> (epc_q == $past(exception_data.pc))
    ) else $error("cp0_regs: EPC not captured on a first-level exception");

endmodule

/* hdl/exception_unit.sv */
`timescale 1ns/1ns

module exception_unit #(
    parameter mips_pkg::word_t exc_vector = mips_pkg::EXC_VECTOR_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  mips_pkg::exec_data_t in,
    input  logic [5:0]           ext_int,
    input  logic                 cp0_we,
    input  mips_pkg::cp0_addr_t  cp0_waddr,
    input  mips_pkg::word_t      cp0_wdata,
    input  mips_pkg::cp0_addr_t  cp0_raddr,
    output logic                 exception_valid,
    output mips_pkg::word_t      pcexception,
    output mips_pkg::exception_t exception_data,
    output mips_pkg::exec_data_t out,
    output mips_pkg::word_t      cp0_rdata
);
    import mips_pkg::*;

    cp0_status_t cp0_status;
    cp0_cause_t  cp0_cause;
    word_t       cp0_epc;

    exception_checker #(
        .exc_vector(exc_vector)
    ) u_checker (
        .reset          (reset),
        .flush          (flush),
        .in             (in),
        .ext_int        (ext_int),
        .cp0_status     (cp0_status),
        .cp0_cause      (cp0_cause),
        .cp0_epc        (cp0_epc),
        .exception_valid(exception_valid),
        .pcexception    (pcexception),
        .exception_data (exception_data),
        .out            (out)
    );

    cp0_regs u_cp0 (
        .clk            (clk),
        .reset          (reset),
        .exception_valid(exception_valid),
        .exception_data (exception_data),
        .we             (cp0_we),
        .waddr          (cp0_waddr),
        .wdata          (cp0_wdata),
        .raddr          (cp0_raddr),
        .status         (cp0_status),
        .cause          (cp0_cause),
        .epc            (cp0_epc),
        .rdata          (cp0_rdata)
    );

endmodule

/* testbench/exception_unit_tb.sv */
`timescale 1ns/1ns

module exception_unit_tb;
    import mips_pkg::*;

    localparam word_t VEC = 32'h8000_0180;

    typedef struct packed {
        logic       valid;
        word_t      vector;
        exception_t info;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        flush;
    exec_data_t  in;
    logic [5:0]  ext_int;
    logic        cp0_we;
    cp0_addr_t   cp0_waddr;
    word_t       cp0_wdata;
    cp0_addr_t   cp0_raddr;
    logic        exception_valid;
    word_t       pcexception;
    exception_t  exception_data;
    exec_data_t  out;
    word_t       cp0_rdata;

    cp0_status_t m_status;  // CP0 shadow model.
    cp0_cause_t  m_cause;
    word_t       m_epc;
    word_t       m_badvaddr;
    word_t       m_count;
    word_t       m_compare;
    logic        m_phase;
    logic        m_in_reset = 1'b0;
    expect_t     m_exp;

    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          irq_taken = 0;
    int          test_errors;
    int          tests;
    int          failed_tests;
    decoded_op_t mem_ops [8];
    cp0_addr_t   read_regs [6];

    exception_unit #(
        .exc_vector(VEC)
    ) uut (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .in             (in),
        .ext_int        (ext_int),
        .cp0_we         (cp0_we),
        .cp0_waddr      (cp0_waddr),
        .cp0_wdata      (cp0_wdata),
        .cp0_raddr      (cp0_raddr),
        .exception_valid(exception_valid),
        .pcexception    (pcexception),
        .exception_data (exception_data),
        .out            (out),
        .cp0_rdata      (cp0_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Expected exception for one memory-stage instruction.
    function automatic expect_t expect_exception(exec_data_t d, logic [5:0] ext, cp0_status_t st,
                                                 cp0_cause_t ca, word_t epc, word_t vec);
        expect_t    e;
        word_t      pc;
        logic [7:0] pend;
        logic       load_bad;
        logic       store_bad;
        pc = d.pcplus4 - 32'd4;
        pend = ({ext, 2'b00} | ca.IP | {ca.TI, 7'd0}) & st.IM;
        load_bad = (d.instr.op == LW && d.result[1:0] != 2'b00)
                   || ((d.instr.op == LH || d.instr.op == LHU) && d.result[0]);
        store_bad = (d.instr.op == SW && d.result[1:0] != 2'b00)
                    || (d.instr.op == SH && d.result[0]);
        e = '0;
        e.valid = 1'b1;
        e.vector = vec;
        if (pend != 8'h00 && st.IE && !st.EXL) e.info.code = INT;
        else if (d.exception_instr) e.info.code = ADEL;
        else if (d.exception_ri) e.info.code = RI;
        else if (d.exception_of) e.info.code = OV;
        else if (d.instr.op == SYSCALL) e.info.code = SYS;
        else if (d.instr.op == BREAK) e.info.code = BP;
        else if (load_bad) e.info.code = ADEL;
        else if (store_bad) e.info.code = ADES;
        else if (d.instr.op == ERET) begin
            e.info.is_eret = 1'b1;
            e.vector = epc;  // Return to EPC.
        end else e.valid = 1'b0;
        e.info.pc = d.in_delay_slot ? pc - 32'd4 : pc;
        e.info.vaddr = d.exception_instr ? pc : d.result;
        e.info.in_delay_slot = d.in_delay_slot;
        return e;
    endfunction

    function automatic word_t model_read(cp0_addr_t a);
        case (a)
            BADVADDR: return m_badvaddr;
            COUNT:    return m_count;
            COMPARE:  return m_compare;
            STATUS:   return m_status;
            CAUSE:    return m_cause;
            EPC:      return m_epc;
            default:  return '0;
        endcase
    endfunction

    function automatic exec_data_t make_instr(decoded_op_t op, word_t pc4, word_t res, logic ds);
        exec_data_t d;
        d = '0;
        d.instr.op = op;
        d.instr.raw = {26'h0, op};
        d.pcplus4 = pc4;
        d.result = res;
        d.in_delay_slot = ds;
        return d;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_exc(string name, exception_t got, exception_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(string name, exec_data_t got, exec_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // Outputs are settled a quarter period after the falling edge.
    always begin
        @(negedge clk);
        #10;
        if (reset) begin
            if (m_in_reset) check_flag("exception_valid", exception_valid, 1'b0);
            m_exp = '0;
        end else begin
            m_exp = expect_exception(in, ext_int, m_status, m_cause, m_epc, VEC);
            if (flush) m_exp = '0;
            if (m_exp.valid && !m_exp.info.is_eret && m_exp.info.code == INT) irq_taken++;
            check_flag("exception_valid", exception_valid, m_exp.valid);
            check_word("pcexception", pcexception, m_exp.vector);
            check_exc("exception_data", exception_data, m_exp.info);
            check_data("out", out, (flush || m_exp.valid) ? exec_data_t'('0) : in);
            check_word("cp0_rdata", cp0_rdata, model_read(cp0_raddr));
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            m_status = '0;
            m_status.EXL = 1'b1;
            m_cause = '0;
            m_epc = '0;
            m_badvaddr = '0;
            m_count = '0;
            m_compare = '0;
            m_phase = 1'b0;
            m_in_reset = 1'b1;
        end else begin
            m_in_reset = 1'b0;
            if (m_count == m_compare) m_cause.TI = 1'b1;
            if (m_phase) m_count = m_count + 32'd1;
            m_phase = ~m_phase;
            if (m_exp.valid && !m_exp.info.is_eret) begin
                if (!m_status.EXL) m_epc = m_exp.info.pc;
                m_status.EXL = 1'b1;
                m_cause.exc_code = m_exp.info.code;
                m_cause.BD = m_exp.info.in_delay_slot;
                if (m_exp.info.code == ADEL || m_exp.info.code == ADES) begin
                    m_badvaddr = m_exp.info.vaddr;
                end
            end else if (m_exp.valid) begin
                m_status.EXL = 1'b0;
            end else if (cp0_we) begin
                case (cp0_waddr)
                    STATUS: begin
                        m_status.IM = cp0_wdata[15:8];
                        m_status.EXL = cp0_wdata[1];
                        m_status.IE = cp0_wdata[0];
                    end
                    CAUSE:   m_cause.IP[1:0] = cp0_wdata[9:8];
                    EPC:     m_epc = cp0_wdata;
                    COUNT:   m_count = cp0_wdata;
                    COMPARE: begin
                        m_compare = cp0_wdata;
                        m_cause.TI = 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    task automatic cycle(exec_data_t d, logic [5:0] ext, logic we, cp0_addr_t wa, word_t wd,
                         cp0_addr_t ra, logic fl);
        @(negedge clk);
        in = d;
        ext_int = ext;
        cp0_we = we;
        cp0_waddr = wa;
        cp0_wdata = wd;
        cp0_raddr = ra;
        flush = fl;
    endtask

    task automatic run_instr(exec_data_t d, cp0_addr_t ra);
        cycle(d, 6'h00, 1'b0, STATUS, 32'h0, ra, 1'b0);
    endtask

    task automatic write_cp0(cp0_addr_t a, word_t v);
        cycle(make_instr(NOP, 32'h0, 32'h0, 1'b0), 6'h00, 1'b1, a, v, a, 1'b0);
    endtask

    task automatic eret_if_needed();
        @(posedge clk);
        #1;
        run_instr(make_instr(m_status.EXL ? ERET : NOP, 32'h0, 32'h0, 1'b0), EPC);
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(string name);
        #15;
        tests++;
        if (errors == test_errors) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - test_errors);
        end
    endtask

    initial begin
        exec_data_t d;
        exec_data_t nop;
        decoded_op_t op;
        word_t r;
        int i;
        int t;
        seed = 32'h8ed77974;
        tests = 0;
        failed_tests = 0;
        mem_ops = '{LW, LH, LHU, LB, LBU, SW, SH, SB};
        read_regs = '{BADVADDR, COUNT, COMPARE, STATUS, CAUSE, EPC};
        nop = make_instr(NOP, 32'h0, 32'h0, 1'b0);
        reset = 1'b1;
        flush = 1'b0;
        in = '0;
        ext_int = 6'h00;
        cp0_we = 1'b0;
        cp0_waddr = STATUS;
        cp0_wdata = 32'h0;
        cp0_raddr = STATUS;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test();
        write_cp0(STATUS, 32'h0);
        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            d = make_instr(mem_ops[r[2:0]], word_t'($random(seed)) & 32'hFFFF_FFFC,
                           $random(seed), r[3]);
            run_instr(d, BADVADDR);
            eret_if_needed();
        end
        end_test("alignment");

        begin_test();
        for (i = 0; i < 120; i++) begin
            r = $random(seed);
            op = (r[3:0] == 4'd15) ? NOP : decoded_op_t'({2'b00, r[3:0]});
            d = make_instr(op, word_t'($random(seed)) & 32'hFFFF_FFFC, $random(seed), r[4]);
            d.exception_instr = r[5] & r[10];
            d.exception_ri = r[6] & r[11];
            d.exception_of = r[7] & r[12];
            run_instr(d, r[8] ? EPC : CAUSE);
            if (r[9]) eret_if_needed();
        end
        eret_if_needed();
        end_test("priority");

        begin_test();
        t = irq_taken;
        for (i = 0; i < 60; i++) begin
            r = $random(seed);
            write_cp0(STATUS, {16'h0, r[15:8], 6'h0, r[1], r[0]});
            write_cp0(CAUSE, {22'h0, r[17:16], 8'h0});
            cycle(nop, r[23:18], 1'b0, STATUS, 32'h0, CAUSE, 1'b0);
        end
        write_cp0(STATUS, 32'h2);  // Second write lands even if an interrupt took the first.
        write_cp0(STATUS, 32'h2);
        write_cp0(CAUSE, 32'h0);
        write_cp0(STATUS, 32'h0);
        if (irq_taken == t) begin
            errors++;
            $display("interrupts: no interrupt was taken");
        end
        end_test("interrupts");

        begin_test();
        run_instr(nop, COUNT);
        write_cp0(COMPARE, m_count + 32'd20);
        write_cp0(STATUS, 32'h0000_8001);
        #15;
        t = 0;
        while (!(exception_valid && exception_data.code == INT) && t < 200) begin
            run_instr(nop, CAUSE);
            #15;
            t++;
        end
        if (t >= 200) begin
            errors++;
            $display("timer: no timer interrupt within 200 cycles");
        end else begin
            check_flag("cause.TI", cp0_rdata[30], 1'b1);
        end
        write_cp0(COMPARE, m_count + 32'h1000);
        run_instr(nop, CAUSE);
        #15;
        check_flag("cause.TI", cp0_rdata[30], 1'b0);
        run_instr(make_instr(ERET, 32'h0, 32'h0, 1'b0), EPC);
        write_cp0(STATUS, 32'h0);
        end_test("timer");

        begin_test();
        write_cp0(STATUS, 32'h0);
        run_instr(make_instr(SYSCALL, 32'h0040_1008, 32'h0, 1'b1), EPC);
        run_instr(nop, EPC);
        #15;
        check_word("epc", cp0_rdata, 32'h0040_1000);
        run_instr(make_instr(BREAK, 32'h0040_2000, 32'h0, 1'b0), CAUSE);
        run_instr(nop, EPC);
        #15;
        check_word("epc", cp0_rdata, 32'h0040_1000);  // Nested, EPC kept.
        run_instr(make_instr(LW, 32'h0040_2004, 32'h1000_0002, 1'b0), BADVADDR);
        run_instr(nop, BADVADDR);
        #15;
        check_word("badvaddr", cp0_rdata, 32'h1000_0002);
        run_instr(nop, CAUSE);
        #15;
        check_word("cause", cp0_rdata & 32'h8000_007C, 32'h0000_0010);
        run_instr(make_instr(ERET, 32'h0, 32'h0, 1'b0), STATUS);
        #15;
        check_word("pcexception", pcexception, 32'h0040_1000);
        run_instr(nop, STATUS);
        #15;
        check_flag("status.EXL", cp0_rdata[1], 1'b0);
        end_test("cp0 update");

        begin_test();
        write_cp0(STATUS, 32'h0000_FF01);
        for (i = 0; i < 20; i++) begin
            r = $random(seed);
            op = (r[3:0] == 4'd15) ? NOP : decoded_op_t'({2'b00, r[3:0]});
            d = make_instr(op, $random(seed), $random(seed), r[4]);
            d.exception_ri = r[5];
            cycle(d, r[11:6], 1'b0, STATUS, 32'h0, read_regs[r[14:12] % 3'd6], 1'b1);
        end
        d.exception_ri = 1'b1;  // Would raise RI if reset did not hold it off.
        cycle(d, 6'h3F, 1'b0, STATUS, 32'h0, STATUS, 1'b0);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        in = '0;
        ext_int = 6'h00;
        run_instr(nop, STATUS);
        #15;
        check_word("status", cp0_rdata, 32'h0000_0002);
        end_test("flush and reset");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks,
                 errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/mips_pkg.sv
hdl/exception.sv
hdl/exception_checker.sv
hdl/cp0_regs.sv
hdl/exception_unit.sv
testbench/exception_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator and run; the exit status follows the testbench result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module exception_unit_tb \
    -f compile.f -o exception_unit_sim || { echo "build failed"; exit 1; }
output="$(./obj_dir/exception_unit_sim 2>&1)"
echo "$output"
echo "$output" | grep -qx "test passed" && exit 0 || exit 1
